/* cpu_pkg.sv */
//////////////////////////////////////////////////
// CPU package for the multicycle MIPS subset core
// Opcodes, ALU ops, sequencer states, control word
//////////////////////////////////////////////////
package cpu_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int BE_W       = 4;
	localparam int V0_IDX     = 2;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_LBU     = 6'h24,
		OP_SB      = 6'h28,
		OP_SW      = 6'h2b
	} op_e;

	typedef enum logic [5:0] {
		F_JR   = 6'h08,
		F_ADDU = 6'h21,
		F_SUBU = 6'h23,
		F_AND  = 6'h24,
		F_OR   = 6'h25,
		F_XOR  = 6'h26,
		F_SLT  = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_LUI
	} alu_op_e;

	typedef enum logic [2:0] {
		S_IDLE_RESET, S_FETCH, S_EXEC, S_MEM, S_HALTED
	} bus_state_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic    use_imm;
		logic    zero_ext;  // ORI
		logic    dest_rt;
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    mem_byte;
		logic    branch_eq;
		logic    branch_ne;
		logic    jump;
		logic    jump_reg;
	} ctrl_t;

endpackage

/* mem_port_if.sv */
//////////////////////////////////////////////////
// One memory request and its response
//////////////////////////////////////////////////
`timescale 1ns/1ps

interface mem_port_if import cpu_pkg::*; ();
	logic            req_read;
	logic            req_write;
	logic [XLEN-1:0] addr;
	logic [XLEN-1:0] wdata;
	logic [BE_W-1:0] be;
	logic [XLEN-1:0] rdata;
	logic            done;  // One cycle, transfer completes on this edge

	modport requester (
		output req_read, req_write, addr, wdata, be,
		input  rdata, done
	);

	modport bus (
		input  req_read, req_write, addr, wdata, be,
		output rdata, done
	);
endinterface

/* bus_sequencer.sv */
//////////////////////////////////////////////////
// Bus sequencer: steps FETCH, EXEC and MEM and
// shares the Avalon master between fetch and data
//////////////////////////////////////////////////
`timescale 1ns/1ps

module bus_sequencer import cpu_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	mem_port_if.bus         fetch,
	mem_port_if.bus         data,
	output logic [XLEN-1:0] address,
	output logic [XLEN-1:0] writedata,
	output logic            read,
	output logic            write,
	output logic [BE_W-1:0] byteenable,
	input  logic            waitrequest,
	input  logic [XLEN-1:0] readdata,
	input  logic            halt_req,
	output bus_state_e      state,
	output logic            active
);
	bus_state_e state_next;
	logic       data_phase;
	logic       xfer_done;

	assign data_phase = (state == S_MEM);

	// Pins follow the port of the current phase
	assign address    = data_phase ? data.addr  : fetch.addr;
	assign writedata  = data_phase ? data.wdata : fetch.wdata;
	assign byteenable = data_phase ? data.be    : fetch.be;

	assign xfer_done  = (read | write) & ~waitrequest;
	assign fetch.done = xfer_done & (state == S_FETCH);
	assign data.done  = xfer_done & data_phase;
	assign fetch.rdata = readdata;
	assign data.rdata  = readdata;

	always_comb begin
		state_next = state;
		case (state)
			S_IDLE_RESET: state_next = S_FETCH;
			S_FETCH: if (fetch.done) state_next = S_EXEC;
			S_EXEC: begin
				if (halt_req)
					state_next = S_HALTED;
				else if (data.req_read | data.req_write)
					state_next = S_MEM;
				else
					state_next = S_FETCH;
			end
			S_MEM: if (data.done) state_next = S_FETCH;
			S_HALTED: state_next = S_HALTED;  // Only reset leaves
			default: state_next = S_IDLE_RESET;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= S_IDLE_RESET;
			read   <= 1'b0;
			write  <= 1'b0;
			active <= 1'b1;
		end else begin
			state  <= state_next;
			active <= (state_next != S_HALTED);
			// Strobes rise on phase entry, fall on completion
			if (state_next == S_FETCH && state != S_FETCH) begin
				read  <= fetch.req_read;
				write <= fetch.req_write;
			end else if (state_next == S_MEM && state != S_MEM) begin
				read  <= data.req_read;
				write <= data.req_write;
			end else if (xfer_done) begin
				read  <= 1'b0;
				write <= 1'b0;
			end
		end
	end

endmodule

/* program_counter.sv */
//////////////////////////////////////////////////
// Program counter with branch, jump and halt detect
//////////////////////////////////////////////////
`timescale 1ns/1ps

module program_counter import cpu_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_VECTOR
) (
	input  logic            clk,
	input  logic            rst_n,
	input  bus_state_e      state,
	input  ctrl_t           ctrl,
	input  logic            branch_taken,
	input  logic [XLEN-1:0] imm,
	input  logic [25:0]     target_index,
	input  logic [XLEN-1:0] rs_value,
	output logic [XLEN-1:0] pc,
	output logic            halt_req
);
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] branch_target;
	logic [XLEN-1:0] jump_target;
	logic [XLEN-1:0] pc_next;

	assign pc_plus4      = pc + 32'd4;
	assign branch_target = pc_plus4 + {imm[XLEN-3:0], 2'b00};
	assign jump_target   = {pc_plus4[31:28], target_index, 2'b00};  // Same 256MB region

	assign halt_req = (state == S_EXEC) && ctrl.jump_reg && (rs_value == '0);

	always_comb begin
		if (ctrl.jump_reg)
			pc_next = rs_value;
		else if (ctrl.jump)
			pc_next = jump_target;
		else if (branch_taken)
			pc_next = branch_target;
		else
			pc_next = pc_plus4;
	end

	// Steps once per instruction; a data phase never reads the PC
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc <= RESET_VECTOR;
		else if (state == S_EXEC && !halt_req)
			pc <= pc_next;
	end

endmodule

/* instr_decoder.sv */
//////////////////////////////////////////////////
// Instruction decoder: control word, immediate and
// destination register
//////////////////////////////////////////////////
`timescale 1ns/1ps

module instr_decoder import cpu_pkg::*; (
	input  logic [XLEN-1:0]       instr,
	output ctrl_t                 ctrl,
	output logic [XLEN-1:0]       imm,
	output logic [REG_ADDR_W-1:0] dest
);
	op_e    op;
	funct_e funct;

	assign op    = op_e'(instr[31:26]);
	assign funct = funct_e'(instr[5:0]);

	always_comb begin
		ctrl = '0;
		case (op)
			OP_SPECIAL: begin
				ctrl.reg_write = 1'b1;
				case (funct)
					F_ADDU: ctrl.alu_op = ALU_ADD;
					F_SUBU: ctrl.alu_op = ALU_SUB;
					F_AND:  ctrl.alu_op = ALU_AND;
					F_OR:   ctrl.alu_op = ALU_OR;
					F_XOR:  ctrl.alu_op = ALU_XOR;
					F_SLT:  ctrl.alu_op = ALU_SLT;
					F_JR: begin
						ctrl.reg_write = 1'b0;
						ctrl.jump_reg  = 1'b1;
					end
					default: ctrl.reg_write = 1'b0;  // Unsupported funct runs as a nop
				endcase
			end
			OP_ADDIU: {ctrl.use_imm, ctrl.dest_rt, ctrl.reg_write} = 3'b111;
			OP_ORI: begin
				ctrl.alu_op = ALU_OR;
				{ctrl.use_imm, ctrl.zero_ext, ctrl.dest_rt, ctrl.reg_write} = 4'b1111;
			end
			OP_LUI: begin
				ctrl.alu_op = ALU_LUI;
				{ctrl.use_imm, ctrl.dest_rt, ctrl.reg_write} = 3'b111;
			end
			OP_LW:  {ctrl.use_imm, ctrl.dest_rt, ctrl.reg_write, ctrl.mem_read} = 4'b1111;
			OP_LBU: begin
				{ctrl.use_imm, ctrl.dest_rt, ctrl.reg_write, ctrl.mem_read} = 4'b1111;
				ctrl.mem_byte = 1'b1;
			end
			OP_SW:  {ctrl.use_imm, ctrl.mem_write} = 2'b11;
			OP_SB:  {ctrl.use_imm, ctrl.mem_write, ctrl.mem_byte} = 3'b111;
			OP_BEQ: ctrl.branch_eq = 1'b1;
			OP_BNE: ctrl.branch_ne = 1'b1;
			OP_J:   ctrl.jump = 1'b1;
			default: ctrl = '0;
		endcase
	end

	assign imm  = ctrl.zero_ext ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
	assign dest = ctrl.dest_rt ? instr[20:16] : instr[15:11];

endmodule

/* reg_file.sv */
//////////////////////////////////////////////////
// 32 x 32 register file, $0 reads zero, v0 tap
//////////////////////////////////////////////////
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [REG_ADDR_W-1:0] rs_addr,
	input  logic [REG_ADDR_W-1:0] rt_addr,
	input  logic [REG_ADDR_W-1:0] wr_addr,
	input  logic                  wr_en,
	input  logic [XLEN-1:0]       wr_data,
	output logic [XLEN-1:0]       rs_data,
	output logic [XLEN-1:0]       rt_data,
	output logic [XLEN-1:0]       v0
);
	logic [XLEN-1:0] regs [0:(1 << REG_ADDR_W)-1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < (1 << REG_ADDR_W); i++)
				regs[i] <= '0;
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];
	assign v0      = regs[V0_IDX];  // Register output, moves on clock edges only

endmodule

/* alu.sv */
//////////////////////////////////////////////////
// ALU for the kept operations plus equality flag
//////////////////////////////////////////////////
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
	input  alu_op_e         op,
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	output logic [XLEN-1:0] y,
	output logic            equal
);
	logic lt_signed;

	assign lt_signed = ($signed(a) < $signed(b));

	always_comb begin
		case (op)
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_AND: y = a & b;
			ALU_OR:  y = a | b;
			ALU_XOR: y = a ^ b;
			ALU_SLT: y = {{(XLEN-1){1'b0}}, lt_signed};
			ALU_LUI: y = {b[15:0], 16'b0};
			default: y = '0;
		endcase
	end

	// BEQ and BNE compare rs with rt
	assign equal = (a == b);

endmodule

/* load_store_unit.sv */
//////////////////////////////////////////////////
// Load/store unit: word address, byte lanes and
// zero-extended LBU result
//////////////////////////////////////////////////
`timescale 1ns/1ps

module load_store_unit import cpu_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  bus_state_e      state,
	input  ctrl_t           ctrl,
	input  logic [XLEN-1:0] eff_addr,
	input  logic [XLEN-1:0] store_data,
	mem_port_if.requester   port,
	output logic [XLEN-1:0] load_data
);
	logic            in_access;
	logic [BE_W-1:0] be_next;
	logic [XLEN-1:0] wdata_next;
	logic [1:0]      lane_q;
	logic            byte_q;
	logic [7:0]      load_byte;

	assign in_access      = (state == S_EXEC) || (state == S_MEM);
	assign port.req_read  = in_access & ctrl.mem_read;
	assign port.req_write = in_access & ctrl.mem_write;

	always_comb begin
		if (ctrl.mem_byte) begin
			be_next    = BE_W'(1) << eff_addr[1:0];  // One-hot lane
			wdata_next = {4{store_data[7:0]}};
		end else begin
			be_next    = '1;
			wdata_next = store_data;
		end
	end

	// Request fields captured in EXEC, held through MEM
	always_ff @(posedge clk) begin
		if (state == S_EXEC) begin
			port.addr  <= {eff_addr[XLEN-1:2], 2'b00};
			port.be    <= be_next;
			port.wdata <= wdata_next;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lane_q <= '0;
			byte_q <= 1'b0;
		end else if (state == S_EXEC) begin
			lane_q <= eff_addr[1:0];
			byte_q <= ctrl.mem_byte;
		end
	end

	assign load_byte = port.rdata[lane_q*8 +: 8];
	assign load_data = byte_q ? {{(XLEN-8){1'b0}}, load_byte} : port.rdata;

endmodule

/* mips_cpu_bus.sv */
//////////////////////////////////////////////////
// MIPS subset core on one Avalon-MM master port
//////////////////////////////////////////////////
`timescale 1ns/1ps

module mips_cpu_bus import cpu_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_VECTOR = 32'hBFC00000
) (
	input  logic        clk,
	input  logic        rst_n,
	output logic        active,
	output logic [31:0] register_v0,
	output logic [31:0] address,
	output logic [31:0] writedata,
	output logic        write,
	output logic        read,
	input  logic        waitrequest,
	output logic [3:0]  byteenable,
	input  logic [31:0] readdata
);
	mem_port_if fetch_port ();
	mem_port_if data_port ();

	bus_state_e            state;
	ctrl_t                 ctrl;
	logic                  halt_req;
	logic                  branch_taken;
	logic                  equal;
	logic                  rf_wr_en;
	logic [REG_ADDR_W-1:0] dest;
	logic [XLEN-1:0]       instr_q;
	logic [XLEN-1:0]       pc;
	logic [XLEN-1:0]       imm;
	logic [XLEN-1:0]       rs_data;
	logic [XLEN-1:0]       rt_data;
	logic [XLEN-1:0]       alu_b;
	logic [XLEN-1:0]       alu_y;
	logic [XLEN-1:0]       load_data;
	logic [XLEN-1:0]       rf_wr_data;

	// Fetch is always a full word read at the PC
	assign fetch_port.req_read  = 1'b1;
	assign fetch_port.req_write = 1'b0;
	assign fetch_port.addr      = pc;
	assign fetch_port.wdata     = '0;
	assign fetch_port.be        = '1;

	always_ff @(posedge clk) begin
		if (fetch_port.done)
			instr_q <= fetch_port.rdata;
	end

	assign alu_b        = ctrl.use_imm ? imm : rt_data;
	assign branch_taken = (ctrl.branch_eq & equal) | (ctrl.branch_ne & ~equal);

	// ALU results land in EXEC, loads when the data read completes
	assign rf_wr_en   = ctrl.mem_read ? data_port.done :
		((state == S_EXEC) & ctrl.reg_write);
	assign rf_wr_data = ctrl.mem_read ? load_data : alu_y;

	bus_sequencer u_seq (
		.clk(clk), .rst_n(rst_n),
		.fetch(fetch_port), .data(data_port),
		.address(address), .writedata(writedata),
		.read(read), .write(write), .byteenable(byteenable),
		.waitrequest(waitrequest), .readdata(readdata),
		.halt_req(halt_req), .state(state), .active(active)
	);

	program_counter #(.RESET_VECTOR(RESET_VECTOR)) u_pc (
		.clk(clk), .rst_n(rst_n), .state(state), .ctrl(ctrl),
		.branch_taken(branch_taken), .imm(imm), .target_index(instr_q[25:0]),
		.rs_value(rs_data), .pc(pc), .halt_req(halt_req)
	);

	instr_decoder u_dec (.instr(instr_q), .ctrl(ctrl), .imm(imm), .dest(dest));

	reg_file u_rf (
		.clk(clk), .rst_n(rst_n),
		.rs_addr(instr_q[25:21]), .rt_addr(instr_q[20:16]), .wr_addr(dest),
		.wr_en(rf_wr_en), .wr_data(rf_wr_data),
		.rs_data(rs_data), .rt_data(rt_data), .v0(register_v0)
	);

	alu u_alu (.op(ctrl.alu_op), .a(rs_data), .b(alu_b), .y(alu_y), .equal(equal));

	load_store_unit u_lsu (
		.clk(clk), .rst_n(rst_n), .state(state), .ctrl(ctrl),
		.eff_addr(alu_y), .store_data(rt_data),
		.port(data_port), .load_data(load_data)
	);

endmodule

/* tb_mips_cpu_bus.sv */
//////////////////////////////////////////////////
// Testbench for the MIPS subset core with an Avalon
// memory model, random waitrequest and reference ISS
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_mips_cpu_bus import cpu_pkg::*;;
	localparam logic [31:0] RESET_VECTOR = 32'hBFC00000;
	localparam logic [31:0] LFSR_SEED    = 32'h9c3fdb97;
	localparam int          MAX_STEPS    = 200;

	logic        clk;
	logic        rst_n;
	logic        active;
	logic [31:0] register_v0;
	logic [31:0] address;
	logic [31:0] writedata;
	logic        write;
	logic        read;
	logic        waitrequest;
	logic [3:0]  byteenable;
	logic [31:0] readdata;

	logic [31:0] bus_mem [logic [31:0]];
	logic [31:0] ref_mem [logic [31:0]];
	logic [31:0] lfsr_state;
	logic [31:0] exp_v0;
	int          errors;
	int          prog_len;
	// Transfer logs observed on the bus and predicted by the ISS
	logic        obs_write [$];
	logic [31:0] obs_addr [$];
	logic [3:0]  obs_be [$];
	logic [31:0] obs_data [$];
	logic        exp_write [$];
	logic [31:0] exp_addr [$];
	logic [3:0]  exp_be [$];
	logic [31:0] exp_data [$];

	mips_cpu_bus #(.RESET_VECTOR(RESET_VECTOR)) i_mips_cpu_bus (
		.clk(clk), .rst_n(rst_n), .active(active), .register_v0(register_v0),
		.address(address), .writedata(writedata), .write(write), .read(read),
		.waitrequest(waitrequest), .byteenable(byteenable), .readdata(readdata)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function logic take_bit();
		take_bit = lfsr_state[0];
		lfsr_state = lfsr_next(lfsr_state);
	endfunction

	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return {a[15:0], a[31:16]} ^ 32'h6b8e31d5;
	endfunction

	function automatic logic [31:0] merge_lanes(input logic [31:0] old_w, new_w,
		input logic [3:0] be);
		logic [31:0] w;
		w = old_w;
		for (int b = 0; b < 4; b++)
			if (be[b])
				w[b*8 +: 8] = new_w[b*8 +: 8];
		return w;
	endfunction

	function logic [31:0] bus_word(input logic [31:0] a);
		return bus_mem.exists(a) ? bus_mem[a] : fill_word(a);
	endfunction

	function logic [31:0] ref_word(input logic [31:0] a);
		return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
	endfunction

	function automatic logic [31:0] enc_r(input logic [4:0] rs, rt, rd,
		input logic [5:0] funct);
		return {6'h00, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs, rt,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic load_program();
		logic [31:0] prog [$];
		logic [31:0] j_addr;
		j_addr = RESET_VECTOR + 32'd104;  // Instruction 26
		prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd8, 16'h1000));  // Data base
		prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd9, 16'hfffb));
		prog.push_back(enc_i(OP_ORI, 5'd0, 5'd10, 16'h80f3));
		prog.push_back(enc_r(5'd9, 5'd10, 5'd11, F_ADDU));
		prog.push_back(enc_r(5'd10, 5'd9, 5'd12, F_SUBU));
		prog.push_back(enc_r(5'd11, 5'd12, 5'd13, F_AND));
		prog.push_back(enc_r(5'd11, 5'd12, 5'd14, F_OR));
		prog.push_back(enc_r(5'd13, 5'd14, 5'd15, F_XOR));
		prog.push_back(enc_r(5'd9, 5'd10, 5'd16, F_SLT));
		prog.push_back(enc_i(OP_LUI, 5'd0, 5'd17, 16'ha5c3));
		prog.push_back(enc_i(OP_ORI, 5'd17, 5'd17, 16'h1e96));
		prog.push_back(enc_i(OP_SW, 5'd8, 5'd17, 16'h0000));
		prog.push_back(enc_i(OP_SW, 5'd8, 5'd15, 16'h000c));  // Logic op results
		prog.push_back(enc_i(OP_SB, 5'd8, 5'd17, 16'h0005));
		prog.push_back(enc_i(OP_SB, 5'd8, 5'd10, 16'h0003));
		prog.push_back(enc_i(OP_LW, 5'd8, 5'd18, 16'h0000));
		prog.push_back(enc_i(OP_LBU, 5'd8, 5'd19, 16'h0003));  // Byte above 0x7f
		prog.push_back(enc_i(OP_LBU, 5'd8, 5'd20, 16'h0005));
		prog.push_back(enc_i(OP_BEQ, 5'd19, 5'd20, 16'h0001));  // Not taken
		prog.push_back(enc_i(OP_BNE, 5'd19, 5'd20, 16'h0001));  // Taken
		prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd2, 16'h7777));
		prog.push_back(enc_r(5'd18, 5'd19, 5'd2, F_ADDU));
		prog.push_back(enc_i(OP_BEQ, 5'd0, 5'd0, 16'h0001));
		prog.push_back(enc_i(OP_ADDIU, 5'd2, 5'd2, 16'h0001));
		prog.push_back({OP_J, j_addr[27:2]});
		prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd2, 16'h1111));
		prog.push_back(enc_r(5'd2, 5'd16, 5'd2, F_ADDU));
		prog.push_back(enc_i(OP_SW, 5'd8, 5'd2, 16'h0008));
		prog.push_back(enc_i(OP_BNE, 5'd0, 5'd0, 16'h0001));
		prog.push_back(enc_r(5'd0, 5'd0, 5'd0, F_JR));  // Halt
		foreach (prog[i]) begin
			bus_mem[RESET_VECTOR + 32'(i * 4)] = prog[i];
			ref_mem[RESET_VECTOR + 32'(i * 4)] = prog[i];
		end
		prog_len = prog.size();
	endtask

	// Reference ISS that logs every bus transfer it expects
	function void iss_run();
		logic [31:0] r [0:31];
		logic [31:0] pc, npc, ins, sext, ea, wa, w;
		logic [4:0]  rs, rt, rd;
		logic [3:0]  be;
		logic        halted;
		int          steps;
		for (int i = 0; i < 32; i++)
			r[i] = '0;
		pc = RESET_VECTOR;
		halted = 1'b0;
		steps = 0;
		while (!halted && steps < MAX_STEPS) begin
			ins = ref_word(pc);
			exp_write.push_back(1'b0);
			exp_addr.push_back(pc);
			exp_be.push_back(4'hf);
			exp_data.push_back(32'h0);
			rs = ins[25:21];
			rt = ins[20:16];
			rd = ins[15:11];
			sext = {{16{ins[15]}}, ins[15:0]};
			ea = r[rs] + sext;
			wa = {ea[31:2], 2'b00};
			be = ((ins[31:26] == OP_LBU) || (ins[31:26] == OP_SB)) ?
				(4'b0001 << ea[1:0]) : 4'hf;
			npc = pc + 32'd4;
			case (ins[31:26])
				OP_SPECIAL: case (ins[5:0])
					F_ADDU: r[rd] = r[rs] + r[rt];
					F_SUBU: r[rd] = r[rs] - r[rt];
					F_AND:  r[rd] = r[rs] & r[rt];
					F_OR:   r[rd] = r[rs] | r[rt];
					F_XOR:  r[rd] = r[rs] ^ r[rt];
					F_SLT:  r[rd] = {31'd0, $signed(r[rs]) < $signed(r[rt])};
					F_JR: begin
						if (r[rs] == 32'h0)
							halted = 1'b1;
						npc = r[rs];
					end
					default: ;
				endcase
				OP_ADDIU: r[rt] = ea;
				OP_ORI:   r[rt] = r[rs] | {16'h0, ins[15:0]};
				OP_LUI:   r[rt] = {ins[15:0], 16'h0};
				OP_LW, OP_LBU: begin
					exp_write.push_back(1'b0);
					exp_addr.push_back(wa);
					exp_be.push_back(be);
					exp_data.push_back(32'h0);
					w = ref_word(wa);
					r[rt] = (ins[31:26] == OP_LW) ? w : {24'd0, w[ea[1:0]*8 +: 8]};
				end
				OP_SW, OP_SB: begin
					w = (ins[31:26] == OP_SW) ? r[rt] : {4{r[rt][7:0]}};
					exp_write.push_back(1'b1);
					exp_addr.push_back(wa);
					exp_be.push_back(be);
					exp_data.push_back(w);
					ref_mem[wa] = merge_lanes(ref_word(wa), w, be);
				end
				OP_BEQ: if (r[rs] == r[rt]) npc = npc + {sext[29:0], 2'b00};
				OP_BNE: if (r[rs] != r[rt]) npc = npc + {sext[29:0], 2'b00};
				OP_J:   npc = {npc[31:28], ins[25:0], 2'b00};
				default: ;
			endcase
			r[0] = '0;
			pc = npc;
			steps++;
		end
		exp_v0 = r[2];
	endfunction

	// Avalon slave decides waitrequest and completes transfers on the falling edge
	always @(negedge clk) begin
		logic wait_now;
		wait_now = take_bit();
		wait_now = wait_now & take_bit();
		if ((read || write) && !wait_now) begin
			if (write)
				bus_mem[address] = merge_lanes(bus_word(address), writedata, byteenable);
			else
				readdata <= bus_word(address);
			obs_write.push_back(write);
			obs_addr.push_back(address);
			obs_be.push_back(byteenable);
			obs_data.push_back(write ? writedata : 32'h0);
		end
		waitrequest <= wait_now;
	end

	initial begin
		wait (prog_len > 0);
		repeat (prog_len * 160) @(posedge clk);
		$display("Timeout: core still active after %0d cycles", prog_len * 160);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b1;  // Falling edge below applies the async reset
		waitrequest = 1'b1;
		readdata = '0;
		errors = 0;
		prog_len = 0;
		lfsr_state = LFSR_SEED;
		load_program();
		iss_run();
		#1 rst_n = 1'b0;
		repeat (2) @(negedge clk);
		check_value("read", 32'(read), 32'h0);
		check_value("write", 32'(write), 32'h0);
		check_value("active", 32'(active), 32'h1);
		rst_n = 1'b1;
		wait (active == 1'b0);
		repeat (5) @(negedge clk);
		check_value("transfer count", 32'(obs_addr.size()), 32'(exp_addr.size()));
		if (obs_addr.size() > 0) begin
			check_value("first address", obs_addr[0], RESET_VECTOR);
			check_value("first byteenable", 32'(obs_be[0]), 32'hf);
		end
		for (int i = 0; i < obs_addr.size() && i < exp_addr.size(); i++) begin
			check_value($sformatf("write[%0d]", i), 32'(obs_write[i]), 32'(exp_write[i]));
			check_value($sformatf("address[%0d]", i), obs_addr[i], exp_addr[i]);
			check_value($sformatf("byteenable[%0d]", i), 32'(obs_be[i]), 32'(exp_be[i]));
			check_value($sformatf("writedata[%0d]", i), obs_data[i], exp_data[i]);
		end
		check_value("register_v0", register_v0, exp_v0);
		foreach (ref_mem[a])
			check_value($sformatf("mem[%h]", a), bus_word(a), ref_mem[a]);
		$display("Run complete: %0d transfers, %0d errors", obs_addr.size(), errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* tb_mips_cpu_bus_chk.sv */
//////////////////////////////////////////////////
// Avalon protocol and reset assertions for the core
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_mips_cpu_bus_chk #(
	parameter logic [31:0] RESET_VECTOR = 32'hBFC00000
) (
	input logic        clk,
	input logic        rst_n,
	input logic        read,
	input logic        write,
	input logic        waitrequest,
	input logic        active,
	input logic [31:0] address,
	input logic [31:0] writedata,
	input logic [3:0]  byteenable
);
	reset_idle: assert property (@(posedge clk) !rst_n |-> !read && !write && active)
		else $error("Bus strobes or active wrong during reset");

	first_fetch: assert property (@(posedge clk) $rose(rst_n) |=>
		read && address == RESET_VECTOR && byteenable == 4'hf)
		else $error("First read not a full word at the reset vector");

	hold_on_wait: assert property (@(posedge clk) disable iff (!rst_n)
		(read || write) && waitrequest |=> $stable(address) && $stable(read) &&
		$stable(write) && $stable(writedata) && $stable(byteenable))
		else $error("Request changed while waitrequest was high");

	one_strobe: assert property (@(posedge clk) disable iff (!rst_n) !(read && write))
		else $error("read and write high together");

	idle_halted: assert property (@(posedge clk) disable iff (!rst_n) !active |-> !read && !write)
		else $error("Transfer after the core halted");
endmodule

bind mips_cpu_bus tb_mips_cpu_bus_chk #(.RESET_VECTOR(RESET_VECTOR)) i_chk (
	.clk(clk), .rst_n(rst_n), .read(read), .write(write),
	.waitrequest(waitrequest), .active(active), .address(address),
	.writedata(writedata), .byteenable(byteenable)
);

/* compile.f */
cpu_pkg.sv
mem_port_if.sv
bus_sequencer.sv
program_counter.sv
instr_decoder.sv
reg_file.sv
alu.sv
load_store_unit.sv
mips_cpu_bus.sv
tb_mips_cpu_bus.sv
tb_mips_cpu_bus_chk.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_mips_cpu_bus
FILELIST = compile.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
